// File: source/alu_pkg.sv
`default_nettype none

package alu_pkg;

  localparam int XLEN = 32;
  typedef logic [XLEN-1:0] word_t;

  // shift and rotate amounts come from the low bits of b
  localparam int SHAMT_W = $clog2(XLEN);
  typedef logic [SHAMT_W-1:0] shamt_t;

  // a count runs 0 to XLEN inclusive
  localparam int COUNT_W = $clog2(XLEN) + 1;

  // pcalau keeps the page, drops the offset
  localparam word_t PAGE_MASK = {{(XLEN - 12){1'b1}}, 12'h000};

  typedef enum logic [4:0] {
    OP_ADD     = 5'd0,
    OP_SUB     = 5'd1,
    OP_SLT     = 5'd2,
    OP_SLTU    = 5'd3,
    OP_LSA     = 5'd4,
    OP_PCALAU  = 5'd5,
    OP_LU12I   = 5'd6,
    OP_AND     = 5'd7,
    OP_ANDN    = 5'd8,
    OP_OR      = 5'd9,
    OP_ORN     = 5'd10,
    OP_XOR     = 5'd11,
    OP_NOR     = 5'd12,
    OP_SLL     = 5'd13,
    OP_SRL     = 5'd14,
    OP_SRA     = 5'd15,
    OP_ROT     = 5'd16,
    OP_CLO_CLZ = 5'd17,
    OP_CTO_CTZ = 5'd18,
    OP_BITREV  = 5'd19,
    OP_BITSWAP = 5'd20,
    OP_REVB    = 5'd21,
    OP_WSBH    = 5'd22,
    OP_DSHD    = 5'd23,
    OP_SEB     = 5'd24,
    OP_SEH     = 5'd25,
    OP_SELNEZ  = 5'd26,
    OP_SELEQZ  = 5'd27
  } alu_op_e;

endpackage

`default_nettype wire

// File: source/alu_operand_if.sv
`timescale 1ns/100ps
`default_nettype none

interface alu_operand_if;

  alu_pkg::alu_op_e op;
  alu_pkg::word_t   a;
  alu_pkg::word_t   b;
  alu_pkg::word_t   c;

  // driven by the stage top
  modport source (output op, a, b, c);

  // read by each function unit
  modport unit (input op, a, b, c);

endinterface

`default_nettype wire

// File: source/arith_logic_unit.sv
`timescale 1ns/100ps
`default_nettype none

module arith_logic_unit (
  alu_operand_if.unit    bus,
  output alu_pkg::word_t result
);

  logic           invb;
  logic           is_lsa;
  logic [2:0]     lsa_shamt;
  alu_pkg::word_t a_in;
  alu_pkg::word_t addend;
  alu_pkg::word_t sum;
  logic           carry;
  logic           overflow;
  logic           slt_bit;
  logic           sltu_bit;

  // sub and both compares run through the adder as a + ~b + 1
  assign invb = (bus.op == alu_pkg::OP_SUB) ||
                (bus.op == alu_pkg::OP_SLT) ||
                (bus.op == alu_pkg::OP_SLTU);

  assign is_lsa = (bus.op == alu_pkg::OP_LSA);

  // lsa scales a by 2 to 16
  assign lsa_shamt = {1'b0, bus.c[1:0]} + 3'd1;
  assign a_in      = is_lsa ? (bus.a << lsa_shamt) : bus.a;
  assign addend    = invb ? ~bus.b : bus.b;

  assign {carry, sum} = a_in + addend + alu_pkg::word_t'(invb);

  // carry into the msb differs from carry out
  assign overflow = a_in[alu_pkg::XLEN-1] ^ addend[alu_pkg::XLEN-1] ^
                    sum[alu_pkg::XLEN-1] ^ carry;

  assign slt_bit  = sum[alu_pkg::XLEN-1] ^ overflow;
  // borrow shows up as a missing carry
  assign sltu_bit = ~carry;

  always_comb begin
    case (bus.op)
      alu_pkg::OP_ADD,
      alu_pkg::OP_SUB,
      alu_pkg::OP_LSA:    result = sum;
      alu_pkg::OP_SLT:    result = alu_pkg::word_t'(slt_bit);
      alu_pkg::OP_SLTU:   result = alu_pkg::word_t'(sltu_bit);
      alu_pkg::OP_PCALAU: result = sum & alu_pkg::PAGE_MASK;
      alu_pkg::OP_LU12I:  result = bus.b;
      alu_pkg::OP_AND:    result = bus.a & bus.b;
      alu_pkg::OP_ANDN:   result = bus.a & ~bus.b;
      alu_pkg::OP_OR:     result = bus.a | bus.b;
      alu_pkg::OP_ORN:    result = bus.a | ~bus.b;
      alu_pkg::OP_XOR:    result = bus.a ^ bus.b;
      alu_pkg::OP_NOR:    result = ~(bus.a | bus.b);
      default:            result = '0;
    endcase
  end

endmodule

`default_nettype wire

// File: source/shift_rotate_unit.sv
`timescale 1ns/100ps
`default_nettype none

module shift_rotate_unit (
  alu_operand_if.unit    bus,
  output alu_pkg::word_t result
);

  alu_pkg::shamt_t              shamt;
  logic                         fill;
  logic [2*alu_pkg::XLEN-1:0]   sr_wide;
  logic [2*alu_pkg::XLEN-1:0]   rot_wide;

  assign shamt = bus.b[alu_pkg::SHAMT_W-1:0];

  // sign fill only for sra
  assign fill = (bus.op == alu_pkg::OP_SRA) & bus.a[alu_pkg::XLEN-1];

  assign sr_wide = {{alu_pkg::XLEN{fill}}, bus.a} >> shamt;

  // low word of a doubled copy gives the right rotate
  assign rot_wide = {bus.a, bus.a} >> shamt;

  always_comb begin
    case (bus.op)
      alu_pkg::OP_SLL: result = bus.a << shamt;
      alu_pkg::OP_SRL,
      alu_pkg::OP_SRA: result = sr_wide[alu_pkg::XLEN-1:0];
      alu_pkg::OP_ROT: result = rot_wide[alu_pkg::XLEN-1:0];
      default:         result = '0;
    endcase
  end

endmodule

`default_nettype wire

// File: source/leading_counter.sv
`timescale 1ns/100ps
`default_nettype none

module leading_counter #(
  parameter int WIDTH = 32
) (
  input  logic [WIDTH-1:0]       value,
  input  logic                   count_ones,
  output logic [$clog2(WIDTH):0] count
);

  localparam int CNT_W = $clog2(WIDTH) + 1;

  generate
    if (WIDTH <= 4) begin : g_leaf
      // walk down from the msb until the run breaks
      always_comb begin
        logic run;
        run   = 1'b1;
        count = '0;
        for (int i = WIDTH - 1; i >= 0; i--) begin
          run   = run & (value[i] == count_ones);
          count = count + CNT_W'(run);
        end
      end
    end else begin : g_split
      localparam int LO_W     = WIDTH / 2;
      localparam int HI_W     = WIDTH - LO_W;
      localparam int HI_CNT_W = $clog2(HI_W) + 1;
      localparam int LO_CNT_W = $clog2(LO_W) + 1;

      logic [HI_CNT_W-1:0] count_hi;
      logic [LO_CNT_W-1:0] count_lo;

      leading_counter #(.WIDTH(HI_W)) u_hi (
        .value      (value[WIDTH-1:LO_W]),
        .count_ones (count_ones),
        .count      (count_hi)
      );

      leading_counter #(.WIDTH(LO_W)) u_lo (
        .value      (value[LO_W-1:0]),
        .count_ones (count_ones),
        .count      (count_lo)
      );

      // low half counts only once the upper half is full
      assign count = (count_hi == HI_CNT_W'(HI_W)) ?
                     CNT_W'(count_hi) + CNT_W'(count_lo) :
                     CNT_W'(count_hi);
    end
  endgenerate

endmodule

`default_nettype wire

// File: source/bit_permute_unit.sv
`timescale 1ns/100ps
`default_nettype none

module bit_permute_unit (
  alu_operand_if.unit    bus,
  output alu_pkg::word_t result
);

  alu_pkg::word_t               bitrev;
  alu_pkg::word_t               bitswap;
  alu_pkg::word_t               count_in;
  logic [alu_pkg::COUNT_W-1:0]  lead_count;
  logic                         b_zero;

  always_comb begin
    for (int i = 0; i < alu_pkg::XLEN; i++) begin
      bitrev[i] = bus.a[alu_pkg::XLEN-1-i];
    end
  end

  // reverse inside each byte, byte order kept
  always_comb begin
    for (int i = 0; i < alu_pkg::XLEN / 8; i++) begin
      for (int j = 0; j < 8; j++) begin
        bitswap[8*i+j] = bus.a[8*i+7-j];
      end
    end
  end

  // trailing count is a leading count of the reversed word
  assign count_in = (bus.op == alu_pkg::OP_CTO_CTZ) ? bitrev : bus.a;

  leading_counter #(.WIDTH(alu_pkg::XLEN)) u_counter (
    .value      (count_in),
    .count_ones (bus.c[0]),
    .count      (lead_count)
  );

  assign b_zero = (bus.b == '0);

  always_comb begin
    case (bus.op)
      alu_pkg::OP_CLO_CLZ,
      alu_pkg::OP_CTO_CTZ: result = alu_pkg::word_t'(lead_count);
      alu_pkg::OP_BITREV:  result = bitrev;
      alu_pkg::OP_BITSWAP: result = bitswap;
      alu_pkg::OP_REVB:    result = {bus.a[7:0], bus.a[15:8], bus.a[23:16], bus.a[31:24]};
      alu_pkg::OP_WSBH:    result = {bus.a[23:16], bus.a[31:24], bus.a[7:0], bus.a[15:8]};
      alu_pkg::OP_DSHD:    result = {bus.a[15:0], bus.a[31:16]};
      alu_pkg::OP_SEB:     result = {{(alu_pkg::XLEN - 8){bus.a[7]}}, bus.a[7:0]};
      alu_pkg::OP_SEH:     result = {{(alu_pkg::XLEN - 16){bus.a[15]}}, bus.a[15:0]};
      alu_pkg::OP_SELNEZ:  result = b_zero ? '0 : bus.a;
      alu_pkg::OP_SELEQZ:  result = b_zero ? bus.a : '0;
      default:             result = '0;
    endcase
  end

endmodule

`default_nettype wire

// File: source/alu_exec_stage.sv
`timescale 1ns/100ps
`default_nettype none

module alu_exec_stage (
  input  logic             clk,
  input  logic             reset,
  input  logic             in_valid,
  input  alu_pkg::alu_op_e op,
  input  alu_pkg::word_t   a,
  input  alu_pkg::word_t   b,
  input  alu_pkg::word_t   c,
  output logic             result_valid,
  output alu_pkg::word_t   result
);

  alu_pkg::word_t arith_result;
  alu_pkg::word_t shift_result;
  alu_pkg::word_t permute_result;
  alu_pkg::word_t merged;

  alu_operand_if operand_bus ();

  assign operand_bus.op = op;
  assign operand_bus.a  = a;
  assign operand_bus.b  = b;
  assign operand_bus.c  = c;

  arith_logic_unit u_arith (
    .bus    (operand_bus),
    .result (arith_result)
  );

  shift_rotate_unit u_shift (
    .bus    (operand_bus),
    .result (shift_result)
  );

  bit_permute_unit u_permute (
    .bus    (operand_bus),
    .result (permute_result)
  );

  // units zero their outputs off-opcode, so a plain or merges them
  assign merged = arith_result | shift_result | permute_result;

  always_ff @(posedge clk) begin
    if (reset) begin
      result_valid <= 1'b0;
      result       <= '0;
    end else begin
      result_valid <= in_valid;
      // hold the last result through idle cycles
      if (in_valid) begin
        result <= merged;
      end
    end
  end

endmodule

`default_nettype wire

// File: verif/alu_ref_model.svh
`ifndef ALU_REF_MODEL_SVH
`define ALU_REF_MODEL_SVH

// expected result of one operation from the instruction rules
function automatic alu_pkg::word_t expected_result(
  input alu_pkg::alu_op_e op,
  input alu_pkg::word_t   a,
  input alu_pkg::word_t   b,
  input alu_pkg::word_t   c
);
  alu_pkg::word_t res;
  int             amt;
  int             run;
  logic           done;
  amt  = int'(b[4:0]);
  res  = '0;
  run  = 0;
  done = 1'b0;
  case (op)
    alu_pkg::OP_ADD:    res = a + b;
    alu_pkg::OP_SUB:    res = a - b;
    alu_pkg::OP_SLT:    res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
    alu_pkg::OP_SLTU:   res = (a < b) ? 32'd1 : 32'd0;
    alu_pkg::OP_LSA:    res = (a << (int'(c[1:0]) + 1)) + b;
    alu_pkg::OP_PCALAU: res = (a + b) & 32'hffff_f000;
    alu_pkg::OP_LU12I:  res = b;
    alu_pkg::OP_AND:    res = a & b;
    alu_pkg::OP_ANDN:   res = a & ~b;
    alu_pkg::OP_OR:     res = a | b;
    alu_pkg::OP_ORN:    res = a | ~b;
    alu_pkg::OP_XOR:    res = a ^ b;
    alu_pkg::OP_NOR:    res = ~(a | b);
    alu_pkg::OP_SLL:    res = a << amt;
    alu_pkg::OP_SRL:    res = a >> amt;
    alu_pkg::OP_SRA:    res = $signed(a) >>> amt;
    // a shift by the full width gives zero, so amount 0 returns a
    alu_pkg::OP_ROT:    res = (a >> amt) | (a << (32 - amt));
    alu_pkg::OP_CLO_CLZ: begin
      for (int i = 31; i >= 0; i--) begin
        if (!done && a[i] == c[0]) run++;
        else done = 1'b1;
      end
      res = run;
    end
    alu_pkg::OP_CTO_CTZ: begin
      for (int i = 0; i < 32; i++) begin
        if (!done && a[i] == c[0]) run++;
        else done = 1'b1;
      end
      res = run;
    end
    alu_pkg::OP_BITREV: begin
      for (int i = 0; i < 32; i++) res[i] = a[31-i];
    end
    alu_pkg::OP_BITSWAP: begin
      for (int i = 0; i < 32; i++) res[i] = a[8*(i/8) + 7 - i%8];
    end
    alu_pkg::OP_REVB: begin
      for (int k = 0; k < 4; k++) res[8*k +: 8] = a[8*(3-k) +: 8];
    end
    // each byte trades places with its neighbour in the halfword
    alu_pkg::OP_WSBH: begin
      for (int k = 0; k < 4; k++) res[8*k +: 8] = a[8*(k ^ 1) +: 8];
    end
    alu_pkg::OP_DSHD:   res = (a >> 16) | (a << 16);
    alu_pkg::OP_SEB:    res = $signed(a[7:0]);
    alu_pkg::OP_SEH:    res = $signed(a[15:0]);
    alu_pkg::OP_SELNEZ: res = (b != 32'd0) ? a : 32'd0;
    alu_pkg::OP_SELEQZ: res = (b == 32'd0) ? a : 32'd0;
    default:            res = '0;
  endcase
  return res;
endfunction

`endif

// File: verif/alu_exec_stage_tb.sv
`timescale 1ns/100ps
`default_nettype none

module alu_exec_stage_tb;

  // about 1400 cycles of stimulus
  localparam int CYCLE_LIMIT = 2000;
  localparam int MIX_OPS     = 300;

  logic             clk;
  logic             reset;
  logic             in_valid;
  alu_pkg::alu_op_e op;
  alu_pkg::word_t   a;
  alu_pkg::word_t   b;
  alu_pkg::word_t   c;
  logic             result_valid;
  alu_pkg::word_t   result;

  alu_pkg::word_t   exp_next;
  alu_pkg::word_t   held_exp;
  alu_pkg::alu_op_e held_op;
  alu_pkg::word_t   held_a;
  alu_pkg::word_t   held_b;
  alu_pkg::word_t   held_c;

  logic [31:0] lfsr_state = 32'hb1a9a3e1;
  int          value_errors = 0;
  int          protocol_errors = 0;
  int          issued = 0;
  int          cycles = 0;

  `include "alu_ref_model.svh"

  alu_exec_stage DUT (
    .clk          (clk),
    .reset        (reset),
    .in_valid     (in_valid),
    .op           (op),
    .a            (a),
    .b            (b),
    .c            (c),
    .result_valid (result_valid),
    .result       (result)
  );

  always #50 clk = ~clk;

  // remember the issued operation until its result shows up
  always @(posedge clk) begin
    if (in_valid) begin
      held_exp <= exp_next;
      held_op  <= op;
      held_a   <= a;
      held_b   <= b;
      held_c   <= c;
    end
  end

  // taps 32, 22, 2, 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      r = {r[30:0], lfsr_state[0]};
    end
    return r;
  endfunction

  function automatic string op_label(input alu_pkg::alu_op_e x);
    return x.name();
  endfunction

  task automatic issue(input alu_pkg::alu_op_e op_in, input alu_pkg::word_t a_in,
                       input alu_pkg::word_t b_in, input alu_pkg::word_t c_in);
    @(negedge clk);
    in_valid = 1'b1;
    op       = op_in;
    a        = a_in;
    b        = b_in;
    c        = c_in;
    exp_next = expected_result(op_in, a_in, b_in, c_in);
    issued++;
  endtask

  task automatic issue_random(input alu_pkg::alu_op_e op_in);
    alu_pkg::word_t ra;
    alu_pkg::word_t rb;
    alu_pkg::word_t rc;
    ra = rand_bits(32);
    rb = rand_bits(32);
    rc = rand_bits(32);
    issue(op_in, ra, rb, rc);
  endtask

  task automatic idle_cycle();
    @(negedge clk);
    in_valid = 1'b0;
  endtask

  valid_follows: assert property (@(posedge clk) disable iff (reset)
    result_valid == $past(in_valid))
    else begin
      protocol_errors++;
      $display("ERROR %0t: result_valid does not follow in_valid by one cycle", $time);
    end

  value_matches: assert property (@(posedge clk) disable iff (reset)
    result_valid |-> result == held_exp)
    else begin
      value_errors++;
      $display("ERROR %0t: %s a=%h b=%h c=%h expected %h got %h", $time,
               op_label($sampled(held_op)), $sampled(held_a), $sampled(held_b),
               $sampled(held_c), $sampled(held_exp), $sampled(result));
    end

  hold_when_idle: assert property (@(posedge clk) disable iff (reset)
    !result_valid |-> $stable(result))
    else begin
      protocol_errors++;
      $display("ERROR %0t: result changed while result_valid was low", $time);
    end

  reset_clears: assert property (@(posedge clk)
    reset |=> (!result_valid && result == '0))
    else begin
      protocol_errors++;
      $display("ERROR %0t: result_valid or result not cleared by reset", $time);
    end

  initial begin
    alu_pkg::word_t ra;
    alu_pkg::word_t rb;
    alu_pkg::word_t rc;
    int             mixed;
    int             amounts[3];
    clk      = 1'b0;
    reset    = 1'b1;
    in_valid = 1'b0;
    op       = alu_pkg::OP_ADD;
    a        = '0;
    b        = '0;
    c        = '0;
    exp_next = '0;
    mixed    = 0;
    amounts  = '{0, 1, 31};
    repeat (5) @(negedge clk);
    reset = 1'b0;
    repeat (3) idle_cycle();

    for (int k = alu_pkg::OP_ADD; k <= alu_pkg::OP_NOR; k++) begin
      repeat (40) issue_random(alu_pkg::alu_op_e'(k));
    end
    // signed overflow corners and equal operands
    for (int k = alu_pkg::OP_ADD; k <= alu_pkg::OP_SLTU; k++) begin
      ra = rand_bits(32);
      issue(alu_pkg::alu_op_e'(k), 32'h7fffffff, 32'h80000000, 32'd0);
      issue(alu_pkg::alu_op_e'(k), 32'h80000000, 32'h7fffffff, 32'd0);
      issue(alu_pkg::alu_op_e'(k), ra, ra, 32'd0);
    end

    for (int k = alu_pkg::OP_SLL; k <= alu_pkg::OP_ROT; k++) begin
      repeat (10) issue_random(alu_pkg::alu_op_e'(k));
      foreach (amounts[j]) begin
        ra = rand_bits(32);
        rb = (rand_bits(27) << 5) | 32'(amounts[j]);
        issue(alu_pkg::alu_op_e'(k), ra, rb, 32'd0);
      end
    end
    foreach (amounts[j]) begin
      ra = rand_bits(32) | 32'h80000000;
      issue(alu_pkg::OP_SRA, ra, 32'(amounts[j]), 32'd0);
    end

    for (int k = alu_pkg::OP_BITREV; k <= alu_pkg::OP_SEH; k++) begin
      repeat (10) issue_random(alu_pkg::alu_op_e'(k));
    end

    // counts over zero, all ones and every single-bit position
    for (int k = alu_pkg::OP_CLO_CLZ; k <= alu_pkg::OP_CTO_CTZ; k++) begin
      for (int cbit = 0; cbit < 2; cbit++) begin
        rc = (rand_bits(31) << 1) | 32'(cbit);
        issue(alu_pkg::alu_op_e'(k), 32'h0, 32'd0, rc);
        issue(alu_pkg::alu_op_e'(k), 32'hffffffff, 32'd0, rc);
        for (int i = 0; i < 32; i++) begin
          issue(alu_pkg::alu_op_e'(k), 32'h1 << i, 32'd0, rc);
          issue(alu_pkg::alu_op_e'(k), ~(32'h1 << i), 32'd0, rc);
        end
      end
    end

    for (int k = alu_pkg::OP_SELNEZ; k <= alu_pkg::OP_SELEQZ; k++) begin
      ra = rand_bits(32);
      rb = rand_bits(32) | 32'h1;
      rc = rand_bits(32);
      issue(alu_pkg::alu_op_e'(k), ra, 32'd0, rc);
      issue(alu_pkg::alu_op_e'(k), ra, rb, rc);
      issue(alu_pkg::alu_op_e'(k), ra, 32'h80000000, rc);
    end

    // mixed opcodes with random gaps
    while (mixed < MIX_OPS) begin
      if (rand_bits(2) == 32'd0) begin
        idle_cycle();
      end else begin
        issue_random(alu_pkg::alu_op_e'(5'(rand_bits(5) % 28)));
        mixed++;
      end
    end

    idle_cycle();
    idle_cycle();
    $display("summary: %0d operations, %0d value errors, %0d protocol errors",
             issued, value_errors, protocol_errors);
    if (value_errors == 0 && protocol_errors == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

  initial begin
    while (cycles < CYCLE_LIMIT) begin
      @(posedge clk);
      cycles++;
    end
    $display("timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
    $display("FAIL: see errors above");
    $finish;
  end

endmodule

`default_nettype wire

// File: filelist.f
+incdir+verif
source/alu_pkg.sv
source/alu_operand_if.sv
source/arith_logic_unit.sv
source/shift_rotate_unit.sv
source/leading_counter.sv
source/bit_permute_unit.sv
source/alu_exec_stage.sv
verif/alu_exec_stage_tb.sv
